// ==== design/rwm_isa_pkg.sv ====
package rwm_isa_pkg;

	// bits 17, 16 and 14 of the instruction word are reserved
	localparam int INST_WIDTH = 20;
	localparam int INST_RET_BIT = 19;
	localparam int INST_RNW_BIT = 18;
	localparam int INST_JUMP_BIT = 15;
	localparam int INST_LOOP_SEL_BIT = 13;
	localparam int INST_AC_LSB = 7;
	localparam int INST_DO_LSB = 3;
	localparam int INST_DM_LSB = 0;

	localparam int NUM_LOOPS = 2;

	typedef logic [INST_WIDTH-1:0] inst_t;
	typedef logic [6:0] pc_t;
	typedef logic [5:0] ac_addr_t;
	typedef logic [7:0] loop_cnt_t;
	typedef logic [3:0] cmd_code_t;
	typedef logic [31:0] host_data_t;
	typedef logic [11:0] host_addr_t;

	// host command code sits in address bits 11..8
	localparam int CMD_CODE_LSB = 8;
	localparam cmd_code_t CMD_RUN = 4'd0;
	localparam cmd_code_t CMD_LOAD_CNTR = 4'd2;
	localparam cmd_code_t CMD_LOAD_JUMP = 4'd3;
	localparam cmd_code_t CMD_CLEAR_ERR = 4'd4;
	localparam cmd_code_t CMD_SET_CS_MASK = 4'd5;
	localparam cmd_code_t CMD_WRITE_INST = 4'd6;
	localparam cmd_code_t CMD_WRITE_AC = 4'd7;

	localparam int ADDR_LOOPBACK_BIT = 7;

	localparam host_addr_t ADDR_STATUS_ERR = 12'd0;
	localparam host_addr_t ADDR_STATUS_PC = 12'd1;

	typedef enum logic [1:0] {
		IDLE,
		RUNNING,
		READING,
		DONE
	} cmd_state_t;

endpackage

// ==== design/rwm_phy_pkg.sv ====
package rwm_phy_pkg;

	localparam int AFI_RATIO = 2;
	localparam int DQ_WIDTH = 8;
	// two data words per AFI phase
	localparam int WORDS = 2 * AFI_RATIO;
	localparam int AC_BUS_WIDTH = 24;
	localparam int CS_BITS = AFI_RATIO;
	localparam int NUM_RANKS = 2;
	localparam int CHK_QUEUE_DEPTH = 4;

	typedef logic [WORDS*DQ_WIDTH-1:0] wdata_t;
	typedef logic [WORDS-1:0] dm_t;
	typedef logic [DQ_WIDTH-1:0] err_word_t;
	typedef logic [AC_BUS_WIDTH-1:0] ac_bus_t;
	// chip select per phase rides above the address/command bus
	typedef logic [AC_BUS_WIDTH+CS_BITS-1:0] ac_word_t;
	typedef logic [NUM_RANKS-1:0] cs_mask_t;
	// phase-major, rank-minor
	typedef logic [CS_BITS*NUM_RANKS-1:0] cs_bus_t;
	typedef logic [WORDS-1:0] do_code_t;
	typedef logic [2:0] dm_code_t;

	// each data word is all ones or all zeros, picked by one code bit
	function automatic wdata_t do_pattern(input do_code_t code);
		wdata_t data;
		for (int w = 0; w < WORDS; w++) begin
			data[w*DQ_WIDTH +: DQ_WIDTH] = {DQ_WIDTH{code[w]}};
		end
		return data;
	endfunction

	// the mask is a thermometer whose code says how many words are masked
	function automatic dm_t dm_pattern(input dm_code_t code);
		dm_t mask;
		for (int w = 0; w < WORDS; w++) begin
			mask[w] = (int'(code) > w);
		end
		return mask;
	endfunction

endpackage

// ==== design/rwm_host_frontend.sv ====
`timescale 1ns/100ps

module rwm_host_frontend (
	input  logic                     afi_clk,
	input  logic                     afi_reset_n,
	input  rwm_isa_pkg::host_addr_t  host_addr_i,
	input  rwm_isa_pkg::host_data_t  host_wdata_i,
	input  logic                     cmd_write_i,
	input  logic                     cmd_read_i,
	input  logic                     ret_seen_i,
	input  rwm_isa_pkg::pc_t         pc_i,
	input  rwm_phy_pkg::err_word_t   err_word_i,
	output logic                     cmd_done_o,
	output rwm_isa_pkg::host_data_t  host_rdata_o,
	output logic                     run_start_o,
	output rwm_isa_pkg::pc_t         run_addr_o,
	output logic                     cntr_load_o,
	output logic                     jump_load_o,
	output logic                     load_sel_o,
	output rwm_isa_pkg::loop_cnt_t   load_value_o,
	output logic                     inst_wr_o,
	output logic                     ac_wr_o,
	output rwm_isa_pkg::pc_t         wr_addr_o,
	output rwm_isa_pkg::host_data_t  wr_data_o,
	output rwm_phy_pkg::cs_mask_t    cs_mask_o,
	output logic                     clear_err_o,
	output logic                     loopback_o
);

	rwm_isa_pkg::host_addr_t addr_r;
	rwm_isa_pkg::host_data_t wdata_r;
	logic cmd_write_r;
	logic cmd_read_r;
	rwm_isa_pkg::cmd_state_t state;
	rwm_isa_pkg::cmd_code_t cmd_code;
	logic write_accept;
	logic set_cs_mask;
	rwm_phy_pkg::cs_mask_t cs_mask_q;
	logic loopback_q;

	always_ff @(posedge afi_clk or negedge afi_reset_n) begin
		if (!afi_reset_n) begin
			cmd_write_r <= 1'b0;
			cmd_read_r <= 1'b0;
		end else begin
			cmd_write_r <= cmd_write_i;
			cmd_read_r <= cmd_read_i;
		end
	end

	always_ff @(posedge afi_clk) begin
		addr_r <= host_addr_i;
		wdata_r <= host_wdata_i;
	end

	assign cmd_code = addr_r[rwm_isa_pkg::CMD_CODE_LSB +: $bits(rwm_isa_pkg::cmd_code_t)];

	// commands are only acted on once, in the cycle the FSM leaves IDLE
	assign write_accept = cmd_write_r && (state == rwm_isa_pkg::IDLE);

	assign run_start_o = write_accept && (cmd_code == rwm_isa_pkg::CMD_RUN);
	assign cntr_load_o = write_accept && (cmd_code == rwm_isa_pkg::CMD_LOAD_CNTR);
	assign jump_load_o = write_accept && (cmd_code == rwm_isa_pkg::CMD_LOAD_JUMP);
	assign clear_err_o = write_accept && (cmd_code == rwm_isa_pkg::CMD_CLEAR_ERR);
	assign set_cs_mask = write_accept && (cmd_code == rwm_isa_pkg::CMD_SET_CS_MASK);
	assign inst_wr_o = write_accept && (cmd_code == rwm_isa_pkg::CMD_WRITE_INST);
	assign ac_wr_o = write_accept && (cmd_code == rwm_isa_pkg::CMD_WRITE_AC);

	assign run_addr_o = wdata_r[$bits(rwm_isa_pkg::pc_t)-1:0];
	assign load_sel_o = addr_r[0];
	assign load_value_o = wdata_r[$bits(rwm_isa_pkg::loop_cnt_t)-1:0];
	assign wr_addr_o = addr_r[$bits(rwm_isa_pkg::pc_t)-1:0];
	assign wr_data_o = wdata_r;

	always_ff @(posedge afi_clk or negedge afi_reset_n) begin
		if (!afi_reset_n) begin
			state <= rwm_isa_pkg::IDLE;
			cs_mask_q <= '0;
			loopback_q <= 1'b0;
		end else begin
			if (set_cs_mask) begin
				cs_mask_q <= wdata_r[$bits(rwm_phy_pkg::cs_mask_t)-1:0];
			end
			case (state)
				rwm_isa_pkg::IDLE: begin
					if (run_start_o) begin
						state <= rwm_isa_pkg::RUNNING;
						loopback_q <= addr_r[rwm_isa_pkg::ADDR_LOOPBACK_BIT];
					end else if (cmd_read_i) begin
						// address is registered by the time READING is left
						state <= rwm_isa_pkg::READING;
					end else if (write_accept) begin
						state <= rwm_isa_pkg::DONE;
					end
				end
				rwm_isa_pkg::RUNNING: begin
					if (ret_seen_i) begin
						state <= rwm_isa_pkg::DONE;
					end
				end
				rwm_isa_pkg::READING: begin
					state <= rwm_isa_pkg::DONE;
				end
				rwm_isa_pkg::DONE: begin
					if (!cmd_write_r && !cmd_read_r) begin
						state <= rwm_isa_pkg::IDLE;
					end
				end
				default: begin
					state <= rwm_isa_pkg::IDLE;
				end
			endcase
		end
	end

	assign cmd_done_o = (state == rwm_isa_pkg::DONE);
	assign cs_mask_o = cs_mask_q;
	assign loopback_o = loopback_q;

	always_comb begin
		host_rdata_o = '0;
		if (addr_r == rwm_isa_pkg::ADDR_STATUS_ERR) begin
			host_rdata_o = rwm_isa_pkg::host_data_t'(err_word_i);
		end else if (addr_r == rwm_isa_pkg::ADDR_STATUS_PC) begin
			host_rdata_o = rwm_isa_pkg::host_data_t'(pc_i);
		end
	end

endmodule

// ==== design/rwm_sequencer.sv ====
`timescale 1ns/100ps

module rwm_sequencer (
	input  logic                    afi_clk,
	input  logic                    afi_reset_n,
	input  logic                    run_start_i,
	input  rwm_isa_pkg::pc_t        run_addr_i,
	input  logic                    cntr_load_i,
	input  logic                    jump_load_i,
	input  logic                    load_sel_i,
	input  rwm_isa_pkg::loop_cnt_t  load_value_i,
	input  logic                    inst_wr_i,
	input  rwm_isa_pkg::pc_t        wr_addr_i,
	input  rwm_isa_pkg::inst_t      wr_data_i,
	output logic                    op_valid_o,
	output rwm_isa_pkg::inst_t      op_o,
	output logic                    ret_seen_o,
	output rwm_isa_pkg::pc_t        pc_o
);

	rwm_isa_pkg::inst_t inst_mem [2**$bits(rwm_isa_pkg::pc_t)];
	rwm_isa_pkg::inst_t op_q;
	rwm_isa_pkg::pc_t pc_q;
	rwm_isa_pkg::pc_t next_pc;
	logic running;
	rwm_isa_pkg::pc_t loop_ptr [rwm_isa_pkg::NUM_LOOPS];
	rwm_isa_pkg::loop_cnt_t loop_init [rwm_isa_pkg::NUM_LOOPS];
	rwm_isa_pkg::loop_cnt_t loop_cnt [rwm_isa_pkg::NUM_LOOPS];
	logic op_ret;
	logic op_jump;
	logic loop_sel;
	logic jump_taken;

	assign op_ret = running && op_q[rwm_isa_pkg::INST_RET_BIT];
	assign op_jump = running && op_q[rwm_isa_pkg::INST_JUMP_BIT];
	assign loop_sel = op_q[rwm_isa_pkg::INST_LOOP_SEL_BIT];

	// a zero counter falls through, so the body runs count+1 times
	assign jump_taken = op_jump && (loop_cnt[loop_sel] != '0);

	always_comb begin
		if (run_start_i) begin
			next_pc = run_addr_i;
		end else if (jump_taken) begin
			next_pc = loop_ptr[loop_sel];
		end else if (op_ret || !running) begin
			next_pc = pc_q;
		end else begin
			next_pc = pc_q + 1'b1;
		end
	end

	// the fetch address is next_pc, so op always matches pc
	always_ff @(posedge afi_clk) begin
		if (inst_wr_i) begin
			inst_mem[wr_addr_i] <= wr_data_i;
		end
		op_q <= inst_mem[next_pc];
	end

	always_ff @(posedge afi_clk or negedge afi_reset_n) begin
		if (!afi_reset_n) begin
			pc_q <= '0;
			running <= 1'b0;
			for (int l = 0; l < rwm_isa_pkg::NUM_LOOPS; l++) begin
				loop_ptr[l] <= '0;
				loop_init[l] <= '0;
				loop_cnt[l] <= '0;
			end
		end else begin
			pc_q <= next_pc;
			if (run_start_i) begin
				running <= 1'b1;
			end else if (op_ret) begin
				running <= 1'b0;
			end
			for (int l = 0; l < rwm_isa_pkg::NUM_LOOPS; l++) begin
				if (cntr_load_i && (load_sel_i == 1'(l))) begin
					loop_init[l] <= load_value_i;
					loop_cnt[l] <= load_value_i;
				end else if (op_jump && (loop_sel == 1'(l))) begin
					loop_cnt[l] <= jump_taken ? loop_cnt[l] - 1'b1 : loop_init[l];
				end
				if (jump_load_i && (load_sel_i == 1'(l))) begin
					loop_ptr[l] <= load_value_i[$bits(rwm_isa_pkg::pc_t)-1:0];
				end
			end
		end
	end

	assign op_valid_o = running;
	assign op_o = op_q;
	assign ret_seen_o = op_ret;
	assign pc_o = pc_q;

endmodule

// ==== design/rwm_pattern_gen.sv ====
`timescale 1ns/100ps

module rwm_pattern_gen (
	input  logic                    afi_clk,
	input  logic                    afi_reset_n,
	input  logic                    op_valid_i,
	input  rwm_isa_pkg::inst_t      op_i,
	input  logic                    ac_wr_i,
	input  rwm_isa_pkg::ac_addr_t   wr_addr_i,
	input  rwm_phy_pkg::ac_word_t   wr_data_i,
	input  rwm_phy_pkg::cs_mask_t   cs_mask_i,
	output rwm_phy_pkg::wdata_t     afi_wdata_o,
	output rwm_phy_pkg::dm_t        afi_dm_o,
	output rwm_phy_pkg::ac_bus_t    ac_bus_o,
	output rwm_phy_pkg::cs_bus_t    cs_bus_o,
	output logic                    wr_beat_o
);

	rwm_phy_pkg::ac_word_t ac_mem [2**$bits(rwm_isa_pkg::ac_addr_t)];
	rwm_isa_pkg::ac_addr_t ac_idx;
	rwm_phy_pkg::ac_word_t ac_word;
	rwm_phy_pkg::do_code_t do_code;
	rwm_phy_pkg::dm_code_t dm_code;
	rwm_phy_pkg::cs_bus_t cs_next;

	assign ac_idx = op_i[rwm_isa_pkg::INST_AC_LSB +: $bits(rwm_isa_pkg::ac_addr_t)];
	assign do_code = op_i[rwm_isa_pkg::INST_DO_LSB +: $bits(rwm_phy_pkg::do_code_t)];
	assign dm_code = op_i[rwm_isa_pkg::INST_DM_LSB +: $bits(rwm_phy_pkg::dm_code_t)];
	assign ac_word = ac_mem[ac_idx];

	always_ff @(posedge afi_clk) begin
		if (ac_wr_i) begin
			ac_mem[wr_addr_i] <= wr_data_i;
		end
	end

	// a masked rank keeps its chip select high in every phase
	always_comb begin
		for (int p = 0; p < rwm_phy_pkg::CS_BITS; p++) begin
			for (int r = 0; r < rwm_phy_pkg::NUM_RANKS; r++) begin
				cs_next[p*rwm_phy_pkg::NUM_RANKS + r] =
					ac_word[rwm_phy_pkg::AC_BUS_WIDTH + p] | cs_mask_i[r];
			end
		end
	end

	always_ff @(posedge afi_clk or negedge afi_reset_n) begin
		if (!afi_reset_n) begin
			cs_bus_o <= '1;
			wr_beat_o <= 1'b0;
		end else begin
			cs_bus_o <= op_valid_i ? cs_next : '1;
			wr_beat_o <= op_valid_i && op_i[rwm_isa_pkg::INST_RNW_BIT];
		end
	end

	always_ff @(posedge afi_clk) begin
		if (op_valid_i) begin
			afi_wdata_o <= rwm_phy_pkg::do_pattern(do_code);
			afi_dm_o <= rwm_phy_pkg::dm_pattern(dm_code);
			ac_bus_o <= ac_word[rwm_phy_pkg::AC_BUS_WIDTH-1:0];
		end else begin
			afi_wdata_o <= '0;
			afi_dm_o <= '0;
			ac_bus_o <= '0;
		end
	end

endmodule

// ==== design/rwm_read_checker.sv ====
`timescale 1ns/100ps

module rwm_read_checker (
	input  logic                    afi_clk,
	input  logic                    afi_reset_n,
	input  logic                    op_valid_i,
	input  rwm_isa_pkg::inst_t      op_i,
	input  rwm_phy_pkg::wdata_t     rdata_i,
	input  logic                    rdata_valid_i,
	input  logic                    clear_err_i,
	output rwm_phy_pkg::err_word_t  err_word_o
);

	rwm_phy_pkg::do_code_t code_q [rwm_phy_pkg::CHK_QUEUE_DEPTH];
	logic [$clog2(rwm_phy_pkg::CHK_QUEUE_DEPTH)-1:0] wr_ptr;
	logic [$clog2(rwm_phy_pkg::CHK_QUEUE_DEPTH)-1:0] rd_ptr;
	logic [$clog2(rwm_phy_pkg::CHK_QUEUE_DEPTH):0] count;
	logic push;
	logic pop;
	rwm_phy_pkg::wdata_t expected;
	rwm_phy_pkg::wdata_t diff;
	rwm_phy_pkg::err_word_t mismatch;
	rwm_phy_pkg::err_word_t err_q;

	// pushes into a full queue are lost, beats on an empty one ignored
	assign push = op_valid_i && op_i[rwm_isa_pkg::INST_RNW_BIT] &&
		(count != rwm_phy_pkg::CHK_QUEUE_DEPTH);
	assign pop = rdata_valid_i && (count != '0);

	assign expected = rwm_phy_pkg::do_pattern(code_q[rd_ptr]);
	assign diff = rdata_i ^ expected;

	// a DQ is in error if any of its words differs
	always_comb begin
		mismatch = '0;
		for (int b = 0; b < rwm_phy_pkg::DQ_WIDTH; b++) begin
			for (int w = 0; w < rwm_phy_pkg::WORDS; w++) begin
				mismatch[b] |= diff[w*rwm_phy_pkg::DQ_WIDTH + b];
			end
		end
	end

	always_ff @(posedge afi_clk) begin
		if (push) begin
			code_q[wr_ptr] <= op_i[rwm_isa_pkg::INST_DO_LSB +: $bits(rwm_phy_pkg::do_code_t)];
		end
	end

	always_ff @(posedge afi_clk or negedge afi_reset_n) begin
		if (!afi_reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			err_q <= '0;
		end else if (clear_err_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			err_q <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
				err_q <= err_q | mismatch;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign err_word_o = err_q;

endmodule

// ==== design/rwm_core.sv ====
`timescale 1ns/100ps

module rwm_core (
	input  logic                     afi_clk,
	input  logic                     afi_reset_n,
	input  rwm_isa_pkg::host_addr_t  host_addr_i,
	input  rwm_isa_pkg::host_data_t  host_wdata_i,
	input  logic                     cmd_write_i,
	input  logic                     cmd_read_i,
	input  rwm_phy_pkg::wdata_t      afi_rdata_i,
	input  logic                     afi_rdata_valid_i,
	output rwm_isa_pkg::host_data_t  host_rdata_o,
	output logic                     cmd_done_o,
	output rwm_phy_pkg::wdata_t      afi_wdata_o,
	output rwm_phy_pkg::dm_t         afi_dm_o,
	output rwm_phy_pkg::ac_bus_t     ac_bus_o,
	output rwm_phy_pkg::cs_bus_t     cs_bus_o
);

	logic run_start;
	rwm_isa_pkg::pc_t run_addr;
	logic cntr_load;
	logic jump_load;
	logic load_sel;
	rwm_isa_pkg::loop_cnt_t load_value;
	logic inst_wr;
	logic ac_wr;
	rwm_isa_pkg::pc_t wr_addr;
	rwm_isa_pkg::host_data_t wr_data;
	rwm_phy_pkg::cs_mask_t cs_mask;
	logic clear_err;
	logic loopback;
	logic ret_seen;
	rwm_isa_pkg::pc_t pc;
	rwm_phy_pkg::err_word_t err_word;
	logic op_valid;
	rwm_isa_pkg::inst_t op;
	rwm_phy_pkg::wdata_t wdata;
	logic wr_beat;
	rwm_phy_pkg::wdata_t chk_rdata;
	logic chk_valid;

	rwm_host_frontend u_frontend (
		.afi_clk(afi_clk), .afi_reset_n(afi_reset_n),
		.host_addr_i(host_addr_i), .host_wdata_i(host_wdata_i),
		.cmd_write_i(cmd_write_i), .cmd_read_i(cmd_read_i),
		.ret_seen_i(ret_seen), .pc_i(pc), .err_word_i(err_word),
		.cmd_done_o(cmd_done_o), .host_rdata_o(host_rdata_o),
		.run_start_o(run_start), .run_addr_o(run_addr),
		.cntr_load_o(cntr_load), .jump_load_o(jump_load),
		.load_sel_o(load_sel), .load_value_o(load_value),
		.inst_wr_o(inst_wr), .ac_wr_o(ac_wr),
		.wr_addr_o(wr_addr), .wr_data_o(wr_data),
		.cs_mask_o(cs_mask), .clear_err_o(clear_err), .loopback_o(loopback)
	);

	rwm_sequencer u_sequencer (
		.afi_clk(afi_clk), .afi_reset_n(afi_reset_n),
		.run_start_i(run_start), .run_addr_i(run_addr),
		.cntr_load_i(cntr_load), .jump_load_i(jump_load),
		.load_sel_i(load_sel), .load_value_i(load_value),
		.inst_wr_i(inst_wr), .wr_addr_i(wr_addr),
		.wr_data_i(wr_data[$bits(rwm_isa_pkg::inst_t)-1:0]),
		.op_valid_o(op_valid), .op_o(op), .ret_seen_o(ret_seen), .pc_o(pc)
	);

	rwm_pattern_gen u_pattern_gen (
		.afi_clk(afi_clk), .afi_reset_n(afi_reset_n),
		.op_valid_i(op_valid), .op_i(op), .ac_wr_i(ac_wr),
		.wr_addr_i(wr_addr[$bits(rwm_isa_pkg::ac_addr_t)-1:0]),
		.wr_data_i(wr_data[$bits(rwm_phy_pkg::ac_word_t)-1:0]),
		.cs_mask_i(cs_mask), .afi_wdata_o(wdata), .afi_dm_o(afi_dm_o),
		.ac_bus_o(ac_bus_o), .cs_bus_o(cs_bus_o), .wr_beat_o(wr_beat)
	);

	// loopback checks the write data stream against its own pattern
	assign chk_rdata = loopback ? wdata : afi_rdata_i;
	assign chk_valid = loopback ? wr_beat : afi_rdata_valid_i;

	rwm_read_checker u_read_checker (
		.afi_clk(afi_clk), .afi_reset_n(afi_reset_n),
		.op_valid_i(op_valid), .op_i(op),
		.rdata_i(chk_rdata), .rdata_valid_i(chk_valid),
		.clear_err_i(clear_err), .err_word_o(err_word)
	);

	assign afi_wdata_o = wdata;

endmodule

// ==== bench/tb_rwm_monitor.sv ====
`timescale 1ns/100ps

module tb_rwm_monitor (
	input  logic                     afi_clk,
	input  logic                     afi_reset_n,
	input  logic                     cmd_done_i,
	input  rwm_isa_pkg::host_data_t  host_rdata_i,
	input  rwm_phy_pkg::cs_bus_t     cs_bus_i,
	input  rwm_phy_pkg::wdata_t      afi_wdata_i,
	input  rwm_phy_pkg::dm_t         afi_dm_i,
	input  rwm_phy_pkg::ac_bus_t     ac_bus_i
);

	int cs_total = 0;
	int cs_base = 0;
	int beat_errs = 0;
	int beat_base = 0;
	int pass_count = 0;
	int fail_count = 0;
	rwm_isa_pkg::host_data_t rdata_cap = '0;
	logic [35:0] beat_exp = '0;
	logic [35:0] beat_act = '0;

	// the test's AC words repeat the data code in bits 3..0 and the mask code in bits 6..4
	function automatic logic [35:0] expected_beat(input rwm_phy_pkg::ac_bus_t ac);
		logic [35:0] beat;
		for (int w = 0; w < 4; w++) begin
			beat[w*8 +: 8] = {8{ac[w]}};
			beat[32 + w] = (ac[6:4] > w);
		end
		return beat;
	endfunction

	// readback is only valid while cmd_done is high
	always @(posedge afi_clk) begin
		if (afi_reset_n && (cs_bus_i != '1)) begin
			cs_total <= cs_total + 1;
			if ({afi_dm_i, afi_wdata_i} !== expected_beat(ac_bus_i)) begin
				beat_errs <= beat_errs + 1;
				beat_exp <= expected_beat(ac_bus_i);
				beat_act <= {afi_dm_i, afi_wdata_i};
			end
		end
		if (cmd_done_i) begin
			rdata_cap <= host_rdata_i;
		end
	end

	task automatic check_reset_state();
		if ((cmd_done_i !== 1'b0) || (cs_bus_i !== '1)) begin
			$display("reset: cmd_done_o or cs_bus_o not idle after reset");
			fail_count++;
		end else begin
			$display("ok   reset");
			pass_count++;
		end
	endtask

	task automatic begin_test();
		cs_base = cs_total;
		beat_base = beat_errs;
	endtask

	task automatic end_test(input string name, input bit check_rdata,
			input rwm_isa_pkg::host_data_t exp_rdata, input int exp_cs);
		bit ok;
		int cs_seen;
		ok = 1'b1;
		cs_seen = cs_total - cs_base;
		if (check_rdata && (rdata_cap !== exp_rdata)) begin
			$display("CHECK FAILED %s readback: expected 0x%08h, actual 0x%08h",
				name, exp_rdata, rdata_cap);
			ok = 1'b0;
		end
		if (cs_seen != exp_cs) begin
			$display("CHECK FAILED %s cs active cycles: expected %0d, actual %0d",
				name, exp_cs, cs_seen);
			ok = 1'b0;
		end
		if (beat_errs != beat_base) begin
			$display("CHECK FAILED %s dm and write data: expected 0x%09h, actual 0x%09h",
				name, beat_exp, beat_act);
			ok = 1'b0;
		end
		if (ok) begin
			$display("ok   %s", name);
			pass_count++;
		end else begin
			fail_count++;
		end
	endtask

	task automatic report_counts(input int assert_fails);
		$display("tests %0d, passed %0d, failed %0d, assertion failures %0d",
			pass_count + fail_count, pass_count, fail_count, assert_fails);
	endtask

endmodule

// ==== bench/tb_rwm_assert.sv ====
`timescale 1ns/100ps

module tb_rwm_assert (
	input  logic afi_clk,
	input  logic afi_reset_n,
	input  logic cmd_write_i,
	input  logic cmd_read_i,
	input  logic cmd_done_i
);

	int fail_count = 0;

	done_low_in_reset: assert property (@(posedge afi_clk) !afi_reset_n |-> !cmd_done_i)
		else begin
			$error("cmd_done_o high while reset is asserted");
			fail_count++;
		end

	done_low_after_reset: assert property (@(posedge afi_clk) $rose(afi_reset_n) |-> !cmd_done_i)
		else begin
			$error("cmd_done_o high right after reset release");
			fail_count++;
		end

	// the host must have been holding a request before done rises
	done_needs_request: assert property (@(posedge afi_clk) disable iff (!afi_reset_n)
		$rose(cmd_done_i) |-> $past(cmd_write_i || cmd_read_i))
		else begin
			$error("cmd_done_o rose without a request");
			fail_count++;
		end

	done_falls_after_release: assert property (@(posedge afi_clk) disable iff (!afi_reset_n)
		$fell(cmd_done_i) |-> $past(!cmd_write_i && !cmd_read_i))
		else begin
			$error("cmd_done_o fell while the request was still high");
			fail_count++;
		end

endmodule

bind rwm_host_frontend tb_rwm_assert u_assert (
	.afi_clk(afi_clk),
	.afi_reset_n(afi_reset_n),
	.cmd_write_i(cmd_write_i),
	.cmd_read_i(cmd_read_i),
	.cmd_done_i(cmd_done_o)
);

// ==== bench/tb_rwm_core.sv ====
`timescale 1ns/100ps

module tb_rwm_core;

	localparam int MAX_STEPS = 32;
	localparam int DONE_TIMEOUT = 200;
	localparam int RD_LAT = 3;
	localparam int LOOP_K = 5;

	logic afi_clk = 1'b0;
	logic afi_reset_n = 1'b0;
	rwm_isa_pkg::host_addr_t host_addr_i = '0;
	rwm_isa_pkg::host_data_t host_wdata_i = '0;
	logic cmd_write_i = 1'b0;
	logic cmd_read_i = 1'b0;
	rwm_phy_pkg::wdata_t afi_rdata_i = '0;
	logic afi_rdata_valid_i = 1'b0;
	rwm_isa_pkg::host_data_t host_rdata_o;
	logic cmd_done_o;
	rwm_phy_pkg::wdata_t afi_wdata_o;
	rwm_phy_pkg::dm_t afi_dm_o;
	rwm_phy_pkg::ac_bus_t ac_bus_o;
	rwm_phy_pkg::cs_bus_t cs_bus_o;

	logic [7:0] lfsr_state = 8'd15;
	logic [2:0] flip_bit = '0;
	logic flip_en = 1'b0;
	logic rsp_valid [RD_LAT] = '{default: 1'b0};
	rwm_phy_pkg::wdata_t rsp_data [RD_LAT] = '{default: '0};

	int n_steps = 0;
	string step_name [MAX_STEPS];
	logic step_rd [MAX_STEPS];
	rwm_isa_pkg::host_addr_t step_addr [MAX_STEPS];
	rwm_isa_pkg::host_data_t step_data [MAX_STEPS];
	logic step_flip [MAX_STEPS];
	rwm_isa_pkg::host_data_t step_rdata [MAX_STEPS];
	int step_cs [MAX_STEPS];

	always #4 afi_clk = ~afi_clk;

	rwm_core uut (
		.afi_clk(afi_clk), .afi_reset_n(afi_reset_n),
		.host_addr_i(host_addr_i), .host_wdata_i(host_wdata_i),
		.cmd_write_i(cmd_write_i), .cmd_read_i(cmd_read_i),
		.afi_rdata_i(afi_rdata_i), .afi_rdata_valid_i(afi_rdata_valid_i),
		.host_rdata_o(host_rdata_o), .cmd_done_o(cmd_done_o),
		.afi_wdata_o(afi_wdata_o), .afi_dm_o(afi_dm_o),
		.ac_bus_o(ac_bus_o), .cs_bus_o(cs_bus_o)
	);

	tb_rwm_monitor u_mon (
		.afi_clk(afi_clk), .afi_reset_n(afi_reset_n), .cmd_done_i(cmd_done_o),
		.host_rdata_i(host_rdata_o), .cs_bus_i(cs_bus_o),
		.afi_wdata_i(afi_wdata_o), .afi_dm_i(afi_dm_o), .ac_bus_i(ac_bus_o)
	);

	// right-shifting Fibonacci LFSR with taps 8 6 5 4
	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		return {s[0] ^ s[2] ^ s[3] ^ s[4], s[7:1]};
	endfunction

	task automatic draw_bits(input int n, output logic [7:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[6:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// each 8-bit word is all ones when its code bit is set
	function automatic rwm_phy_pkg::wdata_t fill_words(input logic [3:0] code);
		rwm_phy_pkg::wdata_t data;
		for (int w = 0; w < 4; w++) begin
			data[w*8 +: 8] = code[w] ? 8'hff : 8'h00;
		end
		return data;
	endfunction

	// the memory model treats ac bus bit 23 as a read and takes its code from the low nibble
	always @(negedge afi_clk) begin
		afi_rdata_valid_i = rsp_valid[RD_LAT-1];
		afi_rdata_i = rsp_data[RD_LAT-1];
		for (int i = RD_LAT - 1; i > 0; i--) begin
			rsp_valid[i] = rsp_valid[i-1];
			rsp_data[i] = rsp_data[i-1];
		end
		rsp_valid[0] = afi_reset_n && (cs_bus_o != '1) && ac_bus_o[23];
		rsp_data[0] = fill_words(ac_bus_o[3:0]);
		if (flip_en) begin
			rsp_data[0][flip_bit] = ~rsp_data[0][flip_bit];
		end
	end

	task automatic add_step(input string name, input logic rd, input rwm_isa_pkg::host_addr_t addr,
			input rwm_isa_pkg::host_data_t data, input logic flip,
			input rwm_isa_pkg::host_data_t exp_rdata, input int exp_cs);
		step_name[n_steps] = name;
		step_rd[n_steps] = rd;
		step_addr[n_steps] = addr;
		step_data[n_steps] = data;
		step_flip[n_steps] = flip;
		step_rdata[n_steps] = exp_rdata;
		step_cs[n_steps] = exp_cs;
		n_steps++;
	endtask

	task automatic build_table();
		// chip selects in AC word bits 25..24 are active low
		// bits 6..4 and 3..0 of a word repeat the mask and data codes of the instruction using it
		add_step("ac_idle", 0, 12'h700, 32'h0300_0000, 0, 0, 0);
		add_step("ac_write", 0, 12'h701, 32'h0000_0025, 0, 0, 0);
		add_step("ac_read", 0, 12'h702, 32'h0080_0005, 0, 0, 0);
		add_step("ac_loop", 0, 12'h703, 32'h0000_0000, 0, 0, 0);
		// write code 5 with mask code 2, read code 5, three idle slots, return at 5
		add_step("inst_0", 0, 12'h600, 32'h0_00aa, 0, 0, 0);
		add_step("inst_1", 0, 12'h601, 32'h4_0128, 0, 0, 0);
		add_step("inst_2", 0, 12'h602, 32'h0, 0, 0, 0);
		add_step("inst_3", 0, 12'h603, 32'h0, 0, 0, 0);
		add_step("inst_4", 0, 12'h604, 32'h0, 0, 0, 0);
		add_step("inst_5", 0, 12'h605, 32'h8_0000, 0, 0, 0);
		// one-instruction loop on pair 0, then return
		add_step("inst_8", 0, 12'h608, 32'h0_8180, 0, 0, 0);
		add_step("inst_9", 0, 12'h609, 32'h8_0000, 0, 0, 0);
		add_step("run_prog", 0, 12'h000, 32'd0, 0, 0, 2);
		add_step("read_pc", 1, 12'h001, 32'd0, 0, 32'd5, 0);
		add_step("read_err_clean", 1, 12'h000, 32'd0, 0, 32'd0, 0);
		// the memory model corrupts its read data here, which loopback must not see
		add_step("run_loopback", 0, 12'h080, 32'd0, 1, 0, 2);
		add_step("read_err_loopback", 1, 12'h000, 32'd0, 0, 32'd0, 0);
		add_step("run_flip", 0, 12'h000, 32'd0, 1, 0, 2);
		add_step("read_err_flip", 1, 12'h000, 32'd0, 0, 32'd1 << flip_bit, 0);
		add_step("clear_err", 0, 12'h400, 32'd0, 0, 0, 0);
		add_step("read_err_cleared", 1, 12'h000, 32'd0, 0, 32'd0, 0);
		add_step("load_cntr", 0, 12'h200, LOOP_K, 0, 0, 0);
		add_step("load_jump", 0, 12'h300, 32'd8, 0, 0, 0);
		add_step("run_loop", 0, 12'h000, 32'd8, 0, 0, LOOP_K + 1);
		add_step("read_pc_loop", 1, 12'h001, 32'd0, 0, 32'd9, 0);
		add_step("set_cs_mask", 0, 12'h500, 32'd3, 0, 0, 0);
		add_step("run_loop_masked", 0, 12'h000, 32'd8, 0, 0, 0);
	endtask

	task automatic host_request(input logic rd, input rwm_isa_pkg::host_addr_t addr,
			input rwm_isa_pkg::host_data_t data, input string name, output bit ok);
		int cycles;
		ok = 1'b1;
		@(negedge afi_clk);
		host_addr_i = addr;
		host_wdata_i = data;
		cmd_read_i = rd;
		cmd_write_i = !rd;
		cycles = 0;
		while ((cmd_done_o !== 1'b1) && (cycles < DONE_TIMEOUT)) begin
			@(negedge afi_clk);
			cycles++;
		end
		cmd_write_i = 1'b0;
		cmd_read_i = 1'b0;
		if (cmd_done_o !== 1'b1) begin
			$display("%s: timed out waiting for cmd_done_o to rise", name);
			ok = 1'b0;
		end else begin
			cycles = 0;
			while ((cmd_done_o !== 1'b0) && (cycles < DONE_TIMEOUT)) begin
				@(negedge afi_clk);
				cycles++;
			end
			if (cmd_done_o !== 1'b0) begin
				$display("%s: timed out waiting for cmd_done_o to fall", name);
				ok = 1'b0;
			end
		end
	endtask

	initial begin : main_seq
		logic [7:0] draw;
		bit ok;
		bit timed_out;
		int assert_fails;
		timed_out = 1'b0;
		draw_bits(3, draw);
		flip_bit = draw[2:0];
		build_table();
		repeat (2) @(negedge afi_clk);
		afi_reset_n = 1'b1;
		@(negedge afi_clk);
		u_mon.check_reset_state();
		for (int i = 0; (i < n_steps) && !timed_out; i++) begin
			flip_en = step_flip[i];
			u_mon.begin_test();
			host_request(step_rd[i], step_addr[i], step_data[i], step_name[i], ok);
			if (!ok) begin
				timed_out = 1'b1;
			end else begin
				u_mon.end_test(step_name[i], step_rd[i], step_rdata[i], step_cs[i]);
			end
		end
		flip_en = 1'b0;
		assert_fails = uut.u_frontend.u_assert.fail_count;
		u_mon.report_counts(assert_fails);
		if (!timed_out && (u_mon.fail_count == 0) && (assert_fails == 0)) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
design/rwm_isa_pkg.sv
design/rwm_phy_pkg.sv
design/rwm_host_frontend.sv
design/rwm_sequencer.sv
design/rwm_pattern_gen.sv
design/rwm_read_checker.sv
design/rwm_core.sv
bench/tb_rwm_monitor.sv
bench/tb_rwm_assert.sv
bench/tb_rwm_core.sv
